// File: hdl/pio_consts.svh
`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

// Number of state machines in the core
`define PIO_NUM_SM 2

// GPIO pins shared by all machines
`define PIO_NUM_PINS 8

`define PIO_FIFO_DEPTH 4  // TX FIFO words per machine

// Instruction memory words, one program for all machines
`define PIO_PROG_WORDS 32

`define PIO_CONF_LEN 8  // Entries in the boot config list

// Min cycles between two loader pushes
`define PIO_PUSH_GAP 16

`endif

// File: hdl/pio_pkg.sv
`include "pio_consts.svh"

package pio_pkg;

  // Loader to core command codes
  typedef enum logic [3:0] {
    NOP     = 4'd0,
    INSTR   = 4'd1,  // Program word
    CLKDIV  = 4'd2,
    PINBASE = 4'd3,
    START   = 4'd4,  // Start PC
    PUSH    = 4'd5,  // TX FIFO word
    ENABLE  = 4'd6
  } pio_action_e;

  typedef enum logic [2:0] {
    JMP  = 3'd0,
    SET  = 3'd1,
    OUT  = 3'd2,
    PULL = 3'd3
  } pio_op_e;

  typedef enum logic [1:0] {
    COND_ALWAYS = 2'd0,
    COND_X_DEC  = 2'd1,  // Taken if X nonzero, X post-decremented
    COND_OSRE   = 2'd2   // Taken if OSR still holds bits
  } pio_cond_e;

  typedef enum logic [1:0] {
    DEST_PINS = 2'd0,
    DEST_X    = 2'd1
  } pio_dest_e;

  // JMP view
  typedef struct packed {
    pio_op_e    op;
    logic [2:0] delay;
    pio_cond_e  cond;
    logic [4:0] target;
    logic [2:0] pad;
  } pio_flow_t;

  // SET and OUT view, value is the SET literal or the OUT bit count
  typedef struct packed {
    pio_op_e    op;
    logic [2:0] delay;
    pio_dest_e  dest;
    logic [4:0] value;
    logic [2:0] pad;
  } pio_data_t;

  typedef union packed {
    pio_flow_t flow;
    pio_data_t data;
  } pio_instr_u;

  typedef struct packed {
    pio_action_e action;
    logic        mindex;  // Target machine
    logic [4:0]  index;   // Program word address
    logic [31:0] data;
  } pio_cmd_t;

  // Already shifted to the machine's pin base
  typedef struct packed {
    logic [`PIO_NUM_PINS-1:0] out;
    logic [`PIO_NUM_PINS-1:0] dir;
  } pio_pins_t;

endpackage

// File: hdl/pio_sm.sv
`include "pio_consts.svh"

module pio_sm (
  input  logic                 clk_25mhz,
  input  logic                 pwr_up_reset_n,
  input  logic [3:0]           cfg_we,    // enable, start, pinbase, clkdiv
  input  logic [31:0]          cfg_data,
  input  logic                 push,
  input  pio_pkg::pio_instr_u  instr,
  output logic [$clog2(`PIO_PROG_WORDS)-1:0] pc,
  output logic                 full,
  output pio_pkg::pio_pins_t   pins
);

  localparam int DEPTH = `PIO_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PC_W  = $clog2(`PIO_PROG_WORDS);
  localparam int NP    = `PIO_NUM_PINS;

  logic [15:0]          clkdiv;
  logic [15:0]          div_cnt;
  logic [$clog2(NP)-1:0] pin_base;
  logic                 en;
  logic [2:0]           delay_cnt;
  logic [31:0]          x;
  logic [31:0]          osr;
  logic [5:0]           osr_cnt;   // Bits left in OSR
  logic [NP-1:0]        out_reg;
  logic [NP-1:0]        dir_reg;

  logic [31:0]          fifo [DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fifo_cnt;

  logic                 tick;
  logic                 fifo_empty;
  logic                 pull_stall;
  logic                 run;
  logic                 pop;
  logic                 do_push;
  logic                 take;
  logic [5:0]           out_len;
  logic [31:0]          bit_mask;
  logic [31:0]          out_bits;

  assign tick       = en && (div_cnt >= clkdiv - 16'd1);
  assign fifo_empty = (fifo_cnt == '0);
  assign full       = (fifo_cnt == CNT_W'(DEPTH));
  assign pull_stall = (instr.data.op == pio_pkg::PULL) && fifo_empty;

  // Instruction issues this cycle, a start PC write wins
  assign run     = tick && !cfg_we[2] && (delay_cnt == 3'd0) && !pull_stall;
  assign pop     = run && (instr.data.op == pio_pkg::PULL);
  assign do_push = push && !full;

  // OUT count of 0 means a full word
  assign out_len  = (instr.data.value == 5'd0) ? 6'd32 : {1'b0, instr.data.value};
  assign bit_mask = (instr.data.value == 5'd0) ? '1 : (32'd1 << instr.data.value) - 32'd1;
  assign out_bits = osr & bit_mask;

  always_comb begin
    case (instr.flow.cond)
      pio_pkg::COND_ALWAYS: take = 1'b1;
      pio_pkg::COND_X_DEC:  take = (x != 32'd0);
      pio_pkg::COND_OSRE:   take = (osr_cnt != 6'd0);
      default:              take = 1'b0;
    endcase
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      clkdiv    <= 16'd1;
      div_cnt   <= '0;
      pin_base  <= '0;
      en        <= 1'b0;
      pc        <= '0;
      delay_cnt <= '0;
      osr_cnt   <= '0;
      out_reg   <= '0;
      dir_reg   <= '0;  // All pins released
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fifo_cnt  <= '0;
    end else begin
      if (cfg_we[0]) clkdiv <= cfg_data[15:0];
      if (cfg_we[1]) pin_base <= cfg_data[$clog2(NP)-1:0];
      if (cfg_we[3]) en <= cfg_data[0];

      if (tick) div_cnt <= '0;
      else if (en) div_cnt <= div_cnt + 16'd1;

      if (cfg_we[2]) begin
        pc        <= cfg_data[PC_W-1:0];
        delay_cnt <= '0;
      end else if (run) begin
        delay_cnt <= instr.flow.delay;
        if (instr.flow.op == pio_pkg::JMP && take) pc <= instr.flow.target;
        else pc <= pc + PC_W'(1);
        case (instr.data.op)
          pio_pkg::SET:
            if (instr.data.dest == pio_pkg::DEST_PINS) begin
              out_reg[0] <= instr.data.value[0];
              dir_reg[0] <= 1'b1;
            end
          pio_pkg::OUT: begin
            osr_cnt <= (osr_cnt > out_len) ? osr_cnt - out_len : 6'd0;
            if (instr.data.dest == pio_pkg::DEST_PINS)
              out_reg <= (out_reg & ~bit_mask[NP-1:0]) | out_bits[NP-1:0];
          end
          pio_pkg::PULL: osr_cnt <= 6'd32;
          default: ;
        endcase
      end else if (tick && delay_cnt != 3'd0) begin
        delay_cnt <= delay_cnt - 3'd1;  // Burn one delay tick
      end

      if (do_push) wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      case ({do_push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + CNT_W'(1);
        2'b01:   fifo_cnt <= fifo_cnt - CNT_W'(1);
        default: ;
      endcase
    end
  end

  // Data path, X, OSR and FIFO storage
  always_ff @(posedge clk_25mhz) begin
    if (do_push) fifo[wr_ptr] <= cfg_data;
    if (run) begin
      case (instr.data.op)
        pio_pkg::JMP:
          if (instr.flow.cond == pio_pkg::COND_X_DEC) x <= x - 32'd1;
        pio_pkg::SET:
          if (instr.data.dest == pio_pkg::DEST_X) x <= {27'd0, instr.data.value};
        pio_pkg::OUT: begin
          if (instr.data.dest == pio_pkg::DEST_X) x <= out_bits;
          osr <= (instr.data.value == 5'd0) ? '0 : osr >> instr.data.value;  // LSB first
        end
        pio_pkg::PULL: osr <= fifo[rd_ptr];
        default: ;
      endcase
    end
  end

  assign pins = '{out: out_reg << pin_base, dir: dir_reg << pin_base};

endmodule

// File: hdl/pio_pin_merge.sv
`include "pio_consts.svh"

module pio_pin_merge (
  input  pio_pkg::pio_pins_t        sm_pins [`PIO_NUM_SM],
  output logic [`PIO_NUM_PINS-1:0]  pins
);

  logic [`PIO_NUM_PINS-1:0] driven;  // Some machine owns the pin
  logic [`PIO_NUM_PINS-1:0] level;

  always_comb begin
    driven = '0;
    level  = '0;
    for (int i = 0; i < `PIO_NUM_SM; i++) begin
      driven |= sm_pins[i].dir;
      // Out bits only count where dir is set
      level |= sm_pins[i].out & sm_pins[i].dir;
    end
  end

  // Undriven pins are pulled up
  assign pins = level | ~driven;

endmodule

// File: hdl/pio_core.sv
`include "pio_consts.svh"

module pio_core (
  input  logic                      clk_25mhz,
  input  logic                      pwr_up_reset_n,
  input  pio_pkg::pio_cmd_t         cmd,
  output logic [`PIO_NUM_SM-1:0]    full,
  output logic [`PIO_NUM_PINS-1:0]  pins
);

  localparam int PC_W = $clog2(`PIO_PROG_WORDS);

  pio_pkg::pio_instr_u imem [`PIO_PROG_WORDS];  // Shared program
  logic [PC_W-1:0]     sm_pc [`PIO_NUM_SM];
  pio_pkg::pio_pins_t  sm_pins [`PIO_NUM_SM];

  always_ff @(posedge clk_25mhz) begin
    if (cmd.action == pio_pkg::INSTR) imem[cmd.index] <= cmd.data[15:0];
  end

  for (genvar i = 0; i < `PIO_NUM_SM; i++) begin : g_sm
    logic       sel;
    logic [3:0] cfg_we;
    logic       push;

    assign sel = (cmd.mindex == 1'(i));

    // Strobes only reach the addressed machine
    assign cfg_we[0] = sel && (cmd.action == pio_pkg::CLKDIV);
    assign cfg_we[1] = sel && (cmd.action == pio_pkg::PINBASE);
    assign cfg_we[2] = sel && (cmd.action == pio_pkg::START);
    assign cfg_we[3] = sel && (cmd.action == pio_pkg::ENABLE);
    assign push      = sel && (cmd.action == pio_pkg::PUSH);

    pio_sm u_sm (
      .clk_25mhz      (clk_25mhz),
      .pwr_up_reset_n (pwr_up_reset_n),
      .cfg_we         (cfg_we),
      .cfg_data       (cmd.data),
      .push           (push),
      .instr          (imem[sm_pc[i]]),  // Async fetch at PC
      .pc             (sm_pc[i]),
      .full           (full[i]),
      .pins           (sm_pins[i])
    );
  end

  pio_pin_merge u_merge (
    .sm_pins (sm_pins),
    .pins    (pins)
  );

endmodule

// File: hdl/pio_loader.sv
`include "pio_consts.svh"

module pio_loader (
  input  logic                    clk_25mhz,
  input  logic                    pwr_up_reset_n,
  output pio_pkg::pio_cmd_t       cmd,
  input  logic [`PIO_NUM_SM-1:0]  full,
  output logic [7:0]              led
);

  localparam int MSG_LEN = 13;
  localparam logic [8*MSG_LEN-1:0] MSG = "Hello World!\n";
  localparam int IDX_W = $clog2(`PIO_PROG_WORDS);
  localparam int CFG_W = $clog2(`PIO_CONF_LEN);
  localparam int GAP_W = $clog2(`PIO_PUSH_GAP);

  typedef enum logic [1:0] {LOAD, CONFIG, RUN} state_e;

  state_e           state;
  logic [IDX_W-1:0] idx;      // Program word or config entry
  logic [3:0]       msg_idx;
  logic [GAP_W-1:0] gap_cnt;
  logic [2:0]       stalled;

  function automatic logic [15:0] enc(input pio_pkg::pio_op_e op, input logic [2:0] dly,
                                      input logic [1:0] sel, input logic [4:0] val);
    return {op, dly, sel, val, 3'b000};
  endfunction

  function automatic pio_pkg::pio_cmd_t mk_cmd(input pio_pkg::pio_action_e act,
                                               input logic mi, input logic [31:0] data);
    return '{action: act, mindex: mi, index: 5'd0, data: data};
  endfunction

  // UART TX at word 0, square wave at word 16
  function automatic logic [15:0] prog_word(input logic [IDX_W-1:0] a);
    case (a)
      5'd0:    prog_word = enc(pio_pkg::PULL, 3'd0, 2'd0, 5'd0);
      5'd1:    prog_word = enc(pio_pkg::SET, 3'd0, pio_pkg::DEST_X, 5'd7);
      5'd2:    prog_word = enc(pio_pkg::SET, 3'd7, pio_pkg::DEST_PINS, 5'd0);  // Start bit
      5'd3:    prog_word = enc(pio_pkg::OUT, 3'd0, pio_pkg::DEST_PINS, 5'd1);
      5'd4:    prog_word = enc(pio_pkg::JMP, 3'd6, pio_pkg::COND_X_DEC, 5'd3);
      5'd5:    prog_word = enc(pio_pkg::SET, 3'd7, pio_pkg::DEST_PINS, 5'd1);  // Stop bit
      5'd6:    prog_word = enc(pio_pkg::JMP, 3'd0, pio_pkg::COND_ALWAYS, 5'd0);
      5'd16:   prog_word = enc(pio_pkg::SET, 3'd7, pio_pkg::DEST_PINS, 5'd1);
      5'd17:   prog_word = enc(pio_pkg::SET, 3'd6, pio_pkg::DEST_PINS, 5'd0);
      5'd18:   prog_word = enc(pio_pkg::JMP, 3'd0, pio_pkg::COND_ALWAYS, 5'd16);
      default: prog_word = enc(pio_pkg::JMP, 3'd0, pio_pkg::COND_ALWAYS, a);  // Park
    endcase
  endfunction

  function automatic pio_pkg::pio_cmd_t conf_entry(input logic [CFG_W-1:0] n);
    case (n)
      3'd0:    conf_entry = mk_cmd(pio_pkg::CLKDIV, 1'b0, 32'd27);  // 216 clk per bit
      3'd1:    conf_entry = mk_cmd(pio_pkg::PINBASE, 1'b0, 32'd0);
      3'd2:    conf_entry = mk_cmd(pio_pkg::START, 1'b0, 32'd0);
      3'd3:    conf_entry = mk_cmd(pio_pkg::CLKDIV, 1'b1, 32'd4);
      3'd4:    conf_entry = mk_cmd(pio_pkg::PINBASE, 1'b1, 32'd1);
      3'd5:    conf_entry = mk_cmd(pio_pkg::START, 1'b1, 32'd16);
      3'd6:    conf_entry = mk_cmd(pio_pkg::ENABLE, 1'b0, 32'd1);
      default: conf_entry = mk_cmd(pio_pkg::ENABLE, 1'b1, 32'd1);
    endcase
  endfunction

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      state   <= LOAD;
      idx     <= '0;
      msg_idx <= '0;
      gap_cnt <= '0;
      stalled <= '0;
      cmd     <= mk_cmd(pio_pkg::NOP, 1'b0, 32'd0);
    end else begin
      case (state)
        LOAD: begin
          cmd <= '{action: pio_pkg::INSTR, mindex: 1'b0, index: idx,
                   data: {16'd0, prog_word(idx)}};
          idx <= idx + IDX_W'(1);
          if (idx == IDX_W'(`PIO_PROG_WORDS - 1)) begin
            state <= CONFIG;
            idx   <= '0;
          end
        end
        CONFIG: begin
          cmd <= conf_entry(idx[CFG_W-1:0]);
          idx <= idx + IDX_W'(1);
          if (idx == IDX_W'(`PIO_CONF_LEN - 1)) state <= RUN;
        end
        RUN: begin
          cmd <= mk_cmd(pio_pkg::NOP, 1'b0, 32'd0);
          if (full[0]) stalled <= stalled + 3'd1;
          if (gap_cnt != GAP_W'(`PIO_PUSH_GAP - 1)) begin
            gap_cnt <= gap_cnt + GAP_W'(1);
          end else if (!full[0]) begin
            // Byte is held until machine 0 has room
            cmd     <= mk_cmd(pio_pkg::PUSH, 1'b0, {24'd0, MSG[8*(MSG_LEN-1-msg_idx) +: 8]});
            gap_cnt <= '0;
            msg_idx <= (msg_idx == 4'(MSG_LEN - 1)) ? 4'd0 : msg_idx + 4'd1;
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

  assign led = ~{5'd0, stalled};

endmodule

// File: hdl/uart_hello_top.sv
`include "pio_consts.svh"

module uart_hello_top (
  input  logic       clk_25mhz,
  input  logic       pwr_up_reset_n,
  input  logic       btn_n,
  output logic       tx,
  output logic       blink,
  output logic [7:0] led
);

  logic                     rst_n;  // Button doubles as reset
  pio_pkg::pio_cmd_t        cmd;
  logic [`PIO_NUM_SM-1:0]   full;
  logic [`PIO_NUM_PINS-1:0] pins;

  assign rst_n = pwr_up_reset_n & btn_n;

  pio_loader u_loader (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (rst_n),
    .cmd            (cmd),
    .full           (full),
    .led            (led)
  );

  pio_core u_core (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (rst_n),
    .cmd            (cmd),
    .full           (full),
    .pins           (pins)
  );

  assign tx    = pins[0];  // Machine 0 UART
  assign blink = pins[1];

endmodule

// File: verification/uart_hello_tb.sv
module uart_hello_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BIT_CYCLES    = 216;  // 8 ticks of 27 clocks
  localparam int EDGE_TIMEOUT  = 6000;
  localparam int LED_TIMEOUT   = 64;
  localparam int BLINK_TIMEOUT = 200;
  localparam int BLINK_PHASE   = 32;   // 8 ticks of 4 clocks

  logic       clk_25mhz;
  logic       pwr_up_reset_n;
  logic       btn_n;
  logic       tx;
  logic       blink;
  logic [7:0] led;

  string msg = "Hello World!\n";
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    seed = 33686;

  uart_hello_top uut (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .btn_n          (btn_n),
    .tx             (tx),
    .blink          (blink),
    .led            (led)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz;
  end

  // Steps over n falling clock edges
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_25mhz);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = 'h%02h, expected 'h%02h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = 'b%08b, expected 'b%08b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp, input int tol);
    if (got < exp - tol || got > exp + tol) begin
      $display("error at %0t ns: %s = %0d cycles, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Hunts for a start bit and samples each bit at its middle
  task automatic recv_frame(output logic [7:0] data, output logic stop_bit, output logic found);
    logic prev;
    int   n;
    data     = '0;
    stop_bit = 1'b0;
    found    = 1'b0;
    n        = 0;
    @(negedge clk_25mhz);
    prev = tx;
    while (!found && n < EDGE_TIMEOUT) begin
      @(negedge clk_25mhz);
      if (prev === 1'b1 && tx === 1'b0) found = 1'b1;
      prev = tx;
      n++;
    end
    if (!found) begin
      $display("timeout at %0t ns: no start bit on tx within %0d cycles", $time, EDGE_TIMEOUT);
      errors++;
      return;
    end
    wait_cycles(BIT_CYCLES / 2);
    check_level("tx start bit", tx, 1'b0);
    for (int b = 0; b < 8; b++) begin
      wait_cycles(BIT_CYCLES);
      data[b] = tx;  // LSB first
    end
    wait_cycles(BIT_CYCLES);
    stop_bit = tx;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int errs_before;
    errs_before = errors;
    @(negedge clk_25mhz);
    check_level("tx", tx, 1'b1);
    check_level("blink", blink, 1'b1);
    check_led("led", led, 8'hff);
    finish_test("reset state", errs_before);
  endtask

  task automatic test_message(input string name);
    int         errs_before;
    logic [7:0] data;
    logic       stop_bit;
    logic       found;
    errs_before = errors;
    for (int i = 0; i < msg.len(); i++) begin
      recv_frame(data, stop_bit, found);
      if (!found) break;
      check_byte("tx byte", data, msg[i]);
      check_level("tx stop bit", stop_bit, 1'b1);
    end
    finish_test(name, errs_before);
  endtask

  // Stall counter should be moving once the FIFO has filled
  task automatic test_stall_led();
    int errs_before;
    int n;
    errs_before = errors;
    n = 0;
    while (led === 8'hff && n < LED_TIMEOUT) begin
      @(negedge clk_25mhz);
      n++;
    end
    if (led === 8'hff) begin
      $display("led stayed all ones for %0d cycles after the first message", LED_TIMEOUT);
      errors++;
    end
    finish_test("stall counter on led", errs_before);
  endtask

  task automatic test_button_reset();
    int         errs_before;
    int         gap;
    logic [7:0] data;
    logic       stop_bit;
    logic       found;
    errs_before = errors;
    for (int i = 0; i < 2; i++) begin
      recv_frame(data, stop_bit, found);
      if (found) check_byte("tx byte", data, msg[i]);
    end
    gap = 200 + ($random(seed) & 255);  // Lands inside the third frame
    wait_cycles(gap);
    @(posedge clk_25mhz);
    #5 btn_n = 1'b0;
    repeat (2) @(posedge clk_25mhz);
    #5 btn_n = 1'b1;
    @(negedge clk_25mhz);
    check_level("tx", tx, 1'b1);
    check_led("led", led, 8'hff);
    recv_frame(data, stop_bit, found);
    if (found) begin
      check_byte("tx byte", data, msg[0]);
      check_level("tx stop bit", stop_bit, 1'b1);
    end
    finish_test("button reset", errs_before);
  endtask

  task automatic wait_blink(input logic level, output int cycles);
    cycles = 0;
    while (blink !== level && cycles < BLINK_TIMEOUT) begin
      @(negedge clk_25mhz);
      cycles++;
    end
    if (blink !== level) begin
      $display("timeout at %0t ns: blink did not go to %b", $time, level);
      errors++;
    end
  endtask

  task automatic test_blink_period();
    int errs_before;
    int low_cycles;
    int high_cycles;
    errs_before = errors;
    @(negedge clk_25mhz);
    wait_blink(1'b1, low_cycles);
    wait_blink(1'b0, high_cycles);  // Aligned to a falling edge
    wait_blink(1'b1, low_cycles);
    wait_blink(1'b0, high_cycles);
    check_cycles("blink low phase", low_cycles, BLINK_PHASE, 1);
    check_cycles("blink high phase", high_cycles, BLINK_PHASE, 1);
    finish_test("blink period", errs_before);
  endtask

  initial begin
    pwr_up_reset_n = 1'b0;
    btn_n          = 1'b1;
    repeat (2) @(posedge clk_25mhz);
    #5 pwr_up_reset_n = 1'b1;

    test_reset_state();
    test_message("first message");
    test_stall_led();
    test_message("repeated message");
    test_button_reset();
    test_blink_period();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: uart_hello_top.f
+incdir+hdl
hdl/pio_pkg.sv
hdl/pio_sm.sv
hdl/pio_pin_merge.sv
hdl/pio_core.sv
hdl/pio_loader.sv
hdl/uart_hello_top.sv
verification/uart_hello_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module uart_hello_tb \
  -f uart_hello_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vuart_hello_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
